// File: lsu_pkg.sv
package lsu_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------

  // Queue entries and index widths
  localparam int LSU_DEPTH = 8;
  localparam int IDX_W     = 3;
  // One bit wider than the index so a full queue can be counted
  localparam int CNT_W     = 4;

  // Instruction tag, address and data widths
  localparam int TAG_W  = 6;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------

  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [CNT_W-1:0]  cnt_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Memory interface FSM
  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_REQ,
    MEM_WAIT
  } mem_state_e;

endpackage : lsu_pkg

// File: lsu_queue.sv
`timescale 1ns/1ps

module lsu_queue (
  input  logic                                        clk_in,
  input  logic                                        rst_N_in,
  // Instruction allocation
  input  logic                                        instr_valid,
  input  lsu_pkg::tag_t                               instr_tag,
  input  logic                                        instr_is_store,
  output logic                                        instr_ready,
  // Address and data, matched by tag
  input  logic                                        data_valid,
  input  lsu_pkg::tag_t                               data_tag,
  input  lsu_pkg::addr_t                              data_addr,
  input  lsu_pkg::data_t                              data_value,
  // Entry state for the issue select
  output logic [lsu_pkg::LSU_DEPTH-1:0]               ent_valid,
  output logic [lsu_pkg::LSU_DEPTH-1:0]               ent_resolved,
  output logic [lsu_pkg::LSU_DEPTH-1:0]               ent_dispatched,
  output logic [lsu_pkg::LSU_DEPTH-1:0]               ent_complete,
  output logic [lsu_pkg::LSU_DEPTH-1:0]               ent_is_store,
  output lsu_pkg::addr_t [lsu_pkg::LSU_DEPTH-1:0]     ent_addr,
  output lsu_pkg::idx_t                               head_ptr,
  // Issue select results
  input  logic                                        fwd_valid,
  input  lsu_pkg::idx_t                               fwd_load_idx,
  input  lsu_pkg::idx_t                               fwd_store_idx,
  input  logic                                        cand_valid,
  input  lsu_pkg::idx_t                               cand_idx,
  // Dispatch to the memory interface
  output logic                                        disp_valid,
  output logic                                        disp_is_store,
  output lsu_pkg::addr_t                              disp_addr,
  output lsu_pkg::data_t                              disp_value,
  output lsu_pkg::tag_t                               disp_tag,
  input  logic                                        disp_ready,
  // Memory done pulse
  input  logic                                        mem_done_valid,
  input  lsu_pkg::tag_t                               mem_done_tag,
  input  lsu_pkg::data_t                              mem_done_value,
  // Completion port
  output logic                                        completion_valid,
  output lsu_pkg::tag_t                               completion_tag,
  output lsu_pkg::data_t                              completion_value
);

  // Entry payload
  lsu_pkg::tag_t  ent_tag   [lsu_pkg::LSU_DEPTH];
  lsu_pkg::data_t ent_value [lsu_pkg::LSU_DEPTH];

  // Ring pointers and occupancy
  lsu_pkg::idx_t tail_ptr;
  lsu_pkg::cnt_t count;

  logic                         alloc;
  logic                         pop;
  logic                         disp_fire;
  logic [lsu_pkg::LSU_DEPTH-1:0] data_hit;
  logic [lsu_pkg::LSU_DEPTH-1:0] mem_hit;
  logic                         ret_valid;
  lsu_pkg::idx_t                ret_idx;

  // ----------------------------------------------------------
  // Handshakes and per-entry matches
  // ----------------------------------------------------------

  assign instr_ready = (count != lsu_pkg::cnt_t'(lsu_pkg::LSU_DEPTH));
  assign alloc       = instr_valid && instr_ready;

  // Head skips one freed slot per cycle
  assign pop = (count != '0) && !ent_valid[head_ptr];

  // Dispatch fields straight from the chosen entry
  assign disp_valid    = cand_valid;
  assign disp_is_store = ent_is_store[cand_idx];
  assign disp_addr     = ent_addr[cand_idx];
  assign disp_value    = ent_value[cand_idx];
  assign disp_tag      = ent_tag[cand_idx];
  assign disp_fire     = disp_valid && disp_ready;

  always_comb begin
    for (int i = 0; i < lsu_pkg::LSU_DEPTH; i++) begin
      // Data goes to the unresolved entry with that tag
      data_hit[i] = data_valid && ent_valid[i] && !ent_resolved[i] &&
                    (ent_tag[i] == data_tag);
      // Memory reply goes to the in-flight entry with that tag
      mem_hit[i]  = mem_done_valid && ent_valid[i] && ent_dispatched[i] &&
                    !ent_complete[i] && (ent_tag[i] == mem_done_tag);
    end
  end

  // Retire the complete entry nearest the head
  always_comb begin
    lsu_pkg::idx_t idx;
    ret_valid = 1'b0;
    ret_idx   = head_ptr;
    for (int k = 0; k < lsu_pkg::LSU_DEPTH; k++) begin
      idx = head_ptr + lsu_pkg::idx_t'(k);
      if (!ret_valid && ent_valid[idx] && ent_complete[idx]) begin
        ret_valid = 1'b1;
        ret_idx   = idx;
      end
    end
  end

  // ----------------------------------------------------------
  // Entry flags and pointers
  // ----------------------------------------------------------

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      ent_valid        <= '0;
      ent_resolved     <= '0;
      ent_dispatched   <= '0;
      ent_complete     <= '0;
      ent_is_store     <= '0;
      head_ptr         <= '0;
      tail_ptr         <= '0;
      count            <= '0;
      completion_valid <= 1'b0;
    end else begin
      if (alloc) begin
        ent_valid[tail_ptr]      <= 1'b1;
        ent_resolved[tail_ptr]   <= 1'b0;
        ent_dispatched[tail_ptr] <= 1'b0;
        ent_complete[tail_ptr]   <= 1'b0;
        ent_is_store[tail_ptr]   <= instr_is_store;
        tail_ptr                 <= tail_ptr + 1'b1;
      end
      for (int i = 0; i < lsu_pkg::LSU_DEPTH; i++) begin
        if (data_hit[i]) begin
          ent_resolved[i] <= 1'b1;
        end
        if (mem_hit[i]) begin
          ent_complete[i] <= 1'b1;
        end
      end
      if (disp_fire) begin
        ent_dispatched[cand_idx] <= 1'b1;
      end
      // Forwarded load is done without touching memory
      if (fwd_valid) begin
        ent_complete[fwd_load_idx] <= 1'b1;
      end
      if (ret_valid) begin
        ent_valid[ret_idx] <= 1'b0;
      end
      if (pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
      if (alloc && !pop) begin
        count <= count + 1'b1;
      end else if (!alloc && pop) begin
        count <= count - 1'b1;
      end
      completion_valid <= ret_valid;
    end
  end

  // ----------------------------------------------------------
  // Payload
  // ----------------------------------------------------------

  always_ff @(posedge clk_in) begin
    if (alloc) begin
      ent_tag[tail_ptr] <= instr_tag;
    end
    for (int i = 0; i < lsu_pkg::LSU_DEPTH; i++) begin
      if (data_hit[i]) begin
        ent_addr[i] <= data_addr;
        // Only a store carries data in from the processor
        if (ent_is_store[i]) begin
          ent_value[i] <= data_value;
        end
      end
      if (mem_hit[i] && !ent_is_store[i]) begin
        ent_value[i] <= mem_done_value;
      end
    end
    if (fwd_valid) begin
      ent_value[fwd_load_idx] <= ent_value[fwd_store_idx];
    end
    if (ret_valid) begin
      completion_tag   <= ent_tag[ret_idx];
      completion_value <= ent_is_store[ret_idx] ? '0 : ent_value[ret_idx];
    end
  end

  // Pointer and count bookkeeping never hands out a live slot
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    alloc |-> !ent_valid[tail_ptr])
    else $error("allocation into a live queue slot");

  // Tags are unique among unresolved entries
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    data_valid |-> $onehot0(data_hit))
    else $error("data strobe matched several entries");

endmodule : lsu_queue

// File: lsu_issue_select.sv
`timescale 1ns/1ps

module lsu_issue_select (
  input  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_valid,
  input  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_resolved,
  input  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_dispatched,
  input  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_complete,
  input  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_is_store,
  input  lsu_pkg::addr_t [lsu_pkg::LSU_DEPTH-1:0] ent_addr,
  input  lsu_pkg::idx_t                           head_ptr,
  output logic                                    fwd_valid,
  output lsu_pkg::idx_t                           fwd_load_idx,
  output lsu_pkg::idx_t                           fwd_store_idx,
  output logic                                    cand_valid,
  output lsu_pkg::idx_t                           cand_idx
);

  logic          load_found;
  lsu_pkg::idx_t load_idx;
  int            load_pos;
  logic          store_found;
  lsu_pkg::idx_t store_idx;
  logic          fwd_hit;

  // ----------------------------------------------------------
  // Walk from the head, oldest first
  // ----------------------------------------------------------

  always_comb begin
    lsu_pkg::idx_t idx;
    logic          blocked;
    logic          store_seen;
    logic          load_pending;
    blocked      = 1'b0;
    store_seen   = 1'b0;
    load_pending = 1'b0;
    load_found   = 1'b0;
    load_idx     = head_ptr;
    load_pos     = 0;
    store_found  = 1'b0;
    store_idx    = head_ptr;
    for (int k = 0; k < lsu_pkg::LSU_DEPTH; k++) begin
      idx = head_ptr + lsu_pkg::idx_t'(k);
      if (ent_valid[idx]) begin
        if (ent_is_store[idx]) begin
          // Only the oldest undispatched store may go out
          if (!store_seen && !ent_dispatched[idx]) begin
            store_seen = 1'b1;
            // A store must not overtake a load still waiting to read
            if (ent_resolved[idx] && !load_pending) begin
              store_found = 1'b1;
              store_idx   = idx;
            end
          end
          // Unknown store address blocks every younger load
          if (!ent_resolved[idx]) begin
            blocked = 1'b1;
          end
        end else if (!ent_dispatched[idx] && !ent_complete[idx]) begin
          if (!load_found && !blocked && ent_resolved[idx]) begin
            load_found = 1'b1;
            load_idx   = idx;
            load_pos   = k;
          end
          load_pending = 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Forwarding source for the chosen load
  // ----------------------------------------------------------

  // Last match in the walk is the youngest older store
  always_comb begin
    lsu_pkg::idx_t idx;
    fwd_hit       = 1'b0;
    fwd_store_idx = head_ptr;
    for (int k = 0; k < lsu_pkg::LSU_DEPTH; k++) begin
      idx = head_ptr + lsu_pkg::idx_t'(k);
      if (load_found && (k < load_pos) && ent_valid[idx] && ent_is_store[idx] &&
          (ent_addr[idx] == ent_addr[load_idx])) begin
        fwd_hit       = 1'b1;
        fwd_store_idx = idx;
      end
    end
  end

  assign fwd_valid    = load_found && fwd_hit;
  assign fwd_load_idx = load_idx;

  // Load wins over store, forwarding wins over memory
  assign cand_valid = load_found ? !fwd_hit : store_found;
  assign cand_idx   = load_found ? load_idx : store_idx;

  // Forward source sits ahead of its load in ring order
  always_comb begin
    if (fwd_valid) begin
      assert (ent_is_store[fwd_store_idx] && !ent_is_store[fwd_load_idx] &&
              ((fwd_store_idx - head_ptr) < (fwd_load_idx - head_ptr)))
        else $error("forwarding pair out of program order");
    end
  end

endmodule : lsu_issue_select

// File: lsu_mem_interface.sv
`timescale 1ns/1ps

module lsu_mem_interface (
  input  logic           clk_in,
  input  logic           rst_N_in,
  // Dispatch from the queue
  input  logic           disp_valid,
  input  logic           disp_is_store,
  input  lsu_pkg::addr_t disp_addr,
  input  lsu_pkg::data_t disp_value,
  input  lsu_pkg::tag_t  disp_tag,
  output logic           disp_ready,
  // L1D request
  output logic           l1d_valid_out,
  output lsu_pkg::addr_t l1d_addr,
  output lsu_pkg::data_t l1d_value,
  output logic           l1d_we,
  // L1D reply
  input  logic           l1d_ready_in,
  input  logic           l1d_resp_valid,
  input  lsu_pkg::data_t l1d_resp_value,
  // Done pulse back to the queue
  output logic           mem_done_valid,
  output lsu_pkg::tag_t  mem_done_tag,
  output lsu_pkg::data_t mem_done_value
);

  lsu_pkg::mem_state_e state;
  // The L1D reply carries no tag, so the request tag is kept here
  lsu_pkg::tag_t       lat_tag;
  logic                disp_fire;
  logic                resp_fire;

  // One transaction in flight, new work only when idle
  assign disp_ready = (state == lsu_pkg::MEM_IDLE);
  assign disp_fire  = disp_valid && disp_ready;
  assign resp_fire  = (state == lsu_pkg::MEM_WAIT) && l1d_resp_valid;

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state          <= lsu_pkg::MEM_IDLE;
      l1d_valid_out  <= 1'b0;
      mem_done_valid <= 1'b0;
    end else begin
      mem_done_valid <= 1'b0;
      case (state)
        lsu_pkg::MEM_IDLE: begin
          if (disp_fire) begin
            state         <= lsu_pkg::MEM_REQ;
            l1d_valid_out <= 1'b1;
          end
        end
        lsu_pkg::MEM_REQ: begin
          // Request held until the L1D takes it
          if (l1d_ready_in) begin
            state         <= lsu_pkg::MEM_WAIT;
            l1d_valid_out <= 1'b0;
          end
        end
        lsu_pkg::MEM_WAIT: begin
          if (l1d_resp_valid) begin
            state          <= lsu_pkg::MEM_IDLE;
            mem_done_valid <= 1'b1;
          end
        end
        default: begin
          state <= lsu_pkg::MEM_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Request and reply payload
  // ----------------------------------------------------------

  always_ff @(posedge clk_in) begin
    if (disp_fire) begin
      l1d_addr  <= disp_addr;
      l1d_value <= disp_value;
      l1d_we    <= disp_is_store;
      lat_tag   <= disp_tag;
    end
    if (resp_fire) begin
      mem_done_tag   <= lat_tag;
      // Stores report zero
      mem_done_value <= l1d_we ? '0 : l1d_resp_value;
    end
  end

  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    l1d_valid_out |-> (state == lsu_pkg::MEM_REQ))
    else $error("L1D request outside MEM_REQ");

  // Stalled request keeps its fields
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (l1d_valid_out && !l1d_ready_in) |=>
      ($stable(l1d_addr) && $stable(l1d_value) && $stable(l1d_we)))
    else $error("L1D request changed under back-pressure");

endmodule : lsu_mem_interface

// File: load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  logic           clk_in,
  input  logic           rst_N_in,
  // Processor instruction strobe
  input  logic           instr_valid,
  input  lsu_pkg::tag_t  instr_tag,
  input  logic           instr_is_store,
  output logic           instr_ready,
  // Processor data strobe
  input  logic           data_valid,
  input  lsu_pkg::tag_t  data_tag,
  input  lsu_pkg::addr_t data_addr,
  input  lsu_pkg::data_t data_value,
  // Completion pulse
  output logic           completion_valid,
  output lsu_pkg::tag_t  completion_tag,
  output lsu_pkg::data_t completion_value,
  // L1D
  output logic           l1d_valid_out,
  output lsu_pkg::addr_t l1d_addr,
  output lsu_pkg::data_t l1d_value,
  output logic           l1d_we,
  input  logic           l1d_ready_in,
  input  logic           l1d_resp_valid,
  input  lsu_pkg::data_t l1d_resp_value
);

  // Queue state seen by the issue select
  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_valid;
  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_resolved;
  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_dispatched;
  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_complete;
  logic [lsu_pkg::LSU_DEPTH-1:0]           ent_is_store;
  lsu_pkg::addr_t [lsu_pkg::LSU_DEPTH-1:0] ent_addr;
  lsu_pkg::idx_t                           head_ptr;

  // Issue select picks
  logic          fwd_valid;
  lsu_pkg::idx_t fwd_load_idx;
  lsu_pkg::idx_t fwd_store_idx;
  logic          cand_valid;
  lsu_pkg::idx_t cand_idx;

  // Dispatch handshake and done pulse
  logic           disp_valid;
  logic           disp_is_store;
  lsu_pkg::addr_t disp_addr;
  lsu_pkg::data_t disp_value;
  lsu_pkg::tag_t  disp_tag;
  logic           disp_ready;
  logic           mem_done_valid;
  lsu_pkg::tag_t  mem_done_tag;
  lsu_pkg::data_t mem_done_value;

  // Port and net names line up one to one
  lsu_queue lsu_queue_inst (.*);

  lsu_issue_select lsu_issue_select_inst (.*);

  lsu_mem_interface lsu_mem_interface_inst (.*);

endmodule : load_store_unit

// File: tb_l1d_responder.sv
`timescale 1ns/1ps

module tb_l1d_responder (
  input  logic           clk_in,
  input  logic           rst_N_in,
  // Request from the DUT
  input  logic           l1d_valid_out,
  input  lsu_pkg::addr_t l1d_addr,
  input  lsu_pkg::data_t l1d_value,
  input  logic           l1d_we,
  // Handshake and reply to the DUT
  output logic           l1d_ready_in,
  output logic           l1d_resp_valid,
  output lsu_pkg::data_t l1d_resp_value,
  // Stores in program order from the testbench
  input  logic           log_valid,
  input  lsu_pkg::addr_t log_addr,
  input  lsu_pkg::data_t log_value,
  output int             error_count,
  output int             write_count
);

  int             seed;
  // Words appear on first write, reads of untouched words get the fill pattern
  lsu_pkg::data_t mem [lsu_pkg::addr_t];
  lsu_pkg::addr_t exp_addr_q [$];
  lsu_pkg::data_t exp_value_q [$];
  int             ready_wait;
  int             resp_wait;
  logic           resp_pending;
  lsu_pkg::data_t resp_data;

  function automatic lsu_pkg::data_t fill_word(lsu_pkg::addr_t a);
    return {a ^ 32'h9e37_79b9, ~a};
  endfunction

  initial begin
    seed           = 32'hb4a9_0207;
    l1d_ready_in   = 1'b0;
    l1d_resp_valid = 1'b0;
    l1d_resp_value = '0;
    error_count    = 0;
    write_count    = 0;
    ready_wait     = 0;
    resp_wait      = 0;
    resp_pending   = 1'b0;
    resp_data      = '0;
  end

  // ----------------------------------------------------------
  // Accept, then reply after a random gap
  // ----------------------------------------------------------

  always @(posedge clk_in) begin
    if (!rst_N_in) begin
      l1d_ready_in   <= 1'b0;
      l1d_resp_valid <= 1'b0;
      resp_pending   = 1'b0;
      ready_wait     = $unsigned($random(seed)) % 4;
    end else begin
      l1d_resp_valid <= 1'b0;
      if (log_valid) begin
        exp_addr_q.push_back(log_addr);
        exp_value_q.push_back(log_value);
      end
      if (l1d_valid_out && l1d_ready_in) begin
        l1d_ready_in <= 1'b0;
        if (l1d_we) begin
          // Writes must match the oldest unwritten store
          if (exp_addr_q.size() == 0) begin
            $display("t=%0t L1D write to 0x%0h with no store waiting", $time, l1d_addr);
            error_count++;
          end else begin
            if (l1d_addr !== exp_addr_q[0]) begin
              $display("ERROR t=%0t l1d_addr got 0x%0h expected 0x%0h",
                       $time, l1d_addr, exp_addr_q[0]);
              error_count++;
            end
            if (l1d_value !== exp_value_q[0]) begin
              $display("ERROR t=%0t l1d_value got 0x%0h expected 0x%0h",
                       $time, l1d_value, exp_value_q[0]);
              error_count++;
            end
            void'(exp_addr_q.pop_front());
            void'(exp_value_q.pop_front());
          end
          mem[l1d_addr] = l1d_value;
          write_count++;
          resp_data = '0;
        end else begin
          resp_data = mem.exists(l1d_addr) ? mem[l1d_addr] : fill_word(l1d_addr);
        end
        resp_wait    = $unsigned($random(seed)) % 4;
        ready_wait   = $unsigned($random(seed)) % 4;
        resp_pending = 1'b1;
      end else if (resp_pending) begin
        if (resp_wait == 0) begin
          l1d_resp_valid <= 1'b1;
          l1d_resp_value <= resp_data;
          resp_pending   = 1'b0;
        end else begin
          resp_wait--;
        end
      end else if (l1d_valid_out) begin
        // Stall a random number of cycles before taking the request
        if (ready_wait == 0) begin
          l1d_ready_in <= 1'b1;
        end else begin
          ready_wait--;
        end
      end
    end
  end

endmodule : tb_l1d_responder

// File: tb_load_store_unit.sv
`timescale 1ns/1ps

module tb_load_store_unit;

  localparam int NUM_OPS    = 400;
  localparam int NUM_WORDS  = 16;
  localparam int MAX_CYCLES = NUM_OPS * 40;
  localparam int NUM_TAGS   = 1 << lsu_pkg::TAG_W;
  localparam lsu_pkg::addr_t ADDR_BASE = 32'h0000_1000;

  // DUT ports
  logic           clk_in;
  logic           rst_N_in;
  logic           instr_valid;
  lsu_pkg::tag_t  instr_tag;
  logic           instr_is_store;
  logic           instr_ready;
  logic           data_valid;
  lsu_pkg::tag_t  data_tag;
  lsu_pkg::addr_t data_addr;
  lsu_pkg::data_t data_value;
  logic           completion_valid;
  lsu_pkg::tag_t  completion_tag;
  lsu_pkg::data_t completion_value;
  logic           l1d_valid_out;
  lsu_pkg::addr_t l1d_addr;
  lsu_pkg::data_t l1d_value;
  logic           l1d_we;
  logic           l1d_ready_in;
  logic           l1d_resp_valid;
  lsu_pkg::data_t l1d_resp_value;

  // Store log to the L1D model and its results
  logic           log_valid;
  lsu_pkg::addr_t log_addr;
  lsu_pkg::data_t log_value;
  int             order_errors;
  int             writes_seen;

  int   seed;
  int   errors;
  int   cycles;
  int   accepted;
  int   completed;
  int   stores_accepted;
  int   outstanding;
  logic timed_out;

  // Per-tag record of accepted operations
  logic           tag_busy   [NUM_TAGS];
  lsu_pkg::data_t tag_expect [NUM_TAGS];
  lsu_pkg::addr_t tag_addr   [NUM_TAGS];
  lsu_pkg::data_t tag_data   [NUM_TAGS];
  lsu_pkg::tag_t  unresolved_q [$];
  lsu_pkg::tag_t  tag_next;

  // Memory image in program order
  lsu_pkg::data_t model_mem [NUM_WORDS];

  // Operation offered but not yet accepted
  logic           pend_valid;
  logic           pend_is_store;
  lsu_pkg::tag_t  pend_tag;
  int             pend_slot;
  lsu_pkg::data_t pend_data;

  load_store_unit load_store_unit_inst (.*);

  tb_l1d_responder l1d_model (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .l1d_valid_out  (l1d_valid_out),
    .l1d_addr       (l1d_addr),
    .l1d_value      (l1d_value),
    .l1d_we         (l1d_we),
    .l1d_ready_in   (l1d_ready_in),
    .l1d_resp_valid (l1d_resp_valid),
    .l1d_resp_value (l1d_resp_value),
    .log_valid      (log_valid),
    .log_addr       (log_addr),
    .log_value      (log_value),
    .error_count    (order_errors),
    .write_count    (writes_seen)
  );

  always #5 clk_in = ~clk_in;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  // Power-up contents of a memory word
  function automatic lsu_pkg::data_t fill_word(lsu_pkg::addr_t a);
    return {a ^ 32'h9e37_79b9, ~a};
  endfunction

  function automatic lsu_pkg::addr_t slot_addr(int slot);
    return ADDR_BASE + lsu_pkg::addr_t'(slot * 8);
  endfunction

  // Next tag with no operation in flight
  function automatic lsu_pkg::tag_t free_tag();
    lsu_pkg::tag_t t;
    t = tag_next;
    while (tag_busy[t]) begin
      t = t + 1'b1;
    end
    tag_next = t + 1'b1;
    return t;
  endfunction

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_failure(string what);
    $display("t=%0t %s", $time, what);
    errors++;
  endtask

  task automatic check_reset_outputs();
    if (completion_valid !== 1'b0) report_mismatch("completion_valid", completion_valid, 0);
    if (l1d_valid_out !== 1'b0) report_mismatch("l1d_valid_out", l1d_valid_out, 0);
    if (instr_ready !== 1'b1) report_mismatch("instr_ready", instr_ready, 1);
  endtask

  // ----------------------------------------------------------
  // Per-cycle monitor and stimulus
  // ----------------------------------------------------------

  task automatic check_completion();
    if (completion_valid === 1'b1) begin
      if (!tag_busy[completion_tag]) begin
        report_failure($sformatf("completion for unknown or already completed tag %0d",
                                 completion_tag));
      end else begin
        if (completion_value !== tag_expect[completion_tag]) begin
          report_mismatch("completion_value", completion_value, tag_expect[completion_tag]);
        end
        tag_busy[completion_tag] = 1'b0;
        outstanding--;
        completed++;
      end
    end
  endtask

  // Program order is the order of acceptance
  task automatic take_instruction();
    log_valid <= 1'b0;
    if (instr_valid && instr_ready) begin
      tag_busy[instr_tag] = 1'b1;
      tag_addr[instr_tag] = slot_addr(pend_slot);
      tag_data[instr_tag] = pend_data;
      if (instr_is_store) begin
        model_mem[pend_slot] = pend_data;
        tag_expect[instr_tag] = '0;
        stores_accepted++;
        log_valid <= 1'b1;
        log_addr  <= slot_addr(pend_slot);
        log_value <= pend_data;
      end else begin
        tag_expect[instr_tag] = model_mem[pend_slot];
      end
      unresolved_q.push_back(instr_tag);
      outstanding++;
      accepted++;
      pend_valid = 1'b0;
    end
  endtask

  task automatic drive_instruction();
    if (!pend_valid && accepted < NUM_OPS && ($random(seed) & 3) != 0) begin
      pend_valid    = 1'b1;
      pend_is_store = $random(seed) & 1;
      pend_slot     = $unsigned($random(seed)) % NUM_WORDS;
      pend_data     = {$random(seed), $random(seed)};
      pend_tag      = free_tag();
    end
    instr_valid    <= pend_valid;
    instr_tag      <= pend_tag;
    instr_is_store <= pend_is_store;
  endtask

  // Address and data of a random unresolved operation
  task automatic drive_data();
    int            j;
    lsu_pkg::tag_t t;
    if (unresolved_q.size() > 0 && ($random(seed) & 1)) begin
      j = $unsigned($random(seed)) % unresolved_q.size();
      t = unresolved_q[j];
      unresolved_q.delete(j);
      data_valid <= 1'b1;
      data_tag   <= t;
      data_addr  <= tag_addr[t];
      data_value <= tag_data[t];
    end else begin
      data_valid <= 1'b0;
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    clk_in         = 1'b0;
    rst_N_in       = 1'b0;
    instr_valid    = 1'b0;
    instr_tag      = '0;
    instr_is_store = 1'b0;
    data_valid     = 1'b0;
    data_tag       = '0;
    data_addr      = '0;
    data_value     = '0;
    log_valid      = 1'b0;
    log_addr       = '0;
    log_value      = '0;
    seed            = 32'hb4a9_0207;
    errors          = 0;
    cycles          = 0;
    accepted        = 0;
    completed       = 0;
    stores_accepted = 0;
    outstanding     = 0;
    timed_out       = 1'b0;
    tag_next        = '0;
    pend_valid      = 1'b0;
    pend_is_store   = 1'b0;
    pend_tag        = '0;
    pend_slot       = 0;
    pend_data       = '0;
    for (int i = 0; i < NUM_TAGS; i++) begin
      tag_busy[i] = 1'b0;
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      model_mem[i] = fill_word(slot_addr(i));
    end
    // Four reset edges, outputs checked once the first has landed
    @(posedge clk_in);
    repeat (3) begin
      @(posedge clk_in);
      check_reset_outputs();
    end
    rst_N_in <= 1'b1;
    @(posedge clk_in);
    check_reset_outputs();
    while (completed < NUM_OPS && !timed_out) begin
      @(posedge clk_in);
      cycles++;
      // TB count never exceeds the queue's own occupancy
      if (outstanding >= lsu_pkg::LSU_DEPTH && instr_ready !== 1'b0) begin
        report_mismatch("instr_ready", instr_ready, 0);
      end
      if (instr_valid && instr_ready && outstanding >= lsu_pkg::LSU_DEPTH) begin
        report_failure("instruction accepted with the queue already full");
      end
      check_completion();
      take_instruction();
      drive_instruction();
      drive_data();
      if (cycles >= MAX_CYCLES) begin
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      report_failure($sformatf("timeout after %0d cycles with %0d of %0d operations completed",
                               cycles, completed, NUM_OPS));
    end
    if (writes_seen != stores_accepted) begin
      report_failure($sformatf("%0d stores accepted but %0d L1D writes seen",
                               stores_accepted, writes_seen));
    end
    $display("errors: %0d checks, %0d store order (%0d operations completed)",
             errors, order_errors, completed);
    if (errors == 0 && order_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_load_store_unit

// File: all.f
lsu_pkg.sv
lsu_queue.sv
lsu_issue_select.sv
lsu_mem_interface.sv
load_store_unit.sv
tb_l1d_responder.sv
tb_load_store_unit.sv

// File: Makefile
# Verilator simulation of the load-store unit
VERILATOR ?= verilator
TOP       ?= tb_load_store_unit
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run into the log, then decide on the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG) && echo "Simulation passed" || \
	  (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
